// File: build.f
+incdir+.
fetchPkg.sv
branchTargetBuffer.sv
directionPredictor.sv
returnAddrStack.sv
instCache.sv
fetchStage1.sv
tbFetchStage1.sv

// File: Bender.yml
package:
  name: fetch_stage1

export_include_dirs:
  - .

sources:
  - fetchPkg.sv
  - branchTargetBuffer.sv
  - directionPredictor.sv
  - returnAddrStack.sv
  - instCache.sv
  - fetchStage1.sv
  - target: test
    files:
      - tbFetchStage1.sv

// File: tbFetchStage1.sv
`include "fetch_params.svh"

module tbFetchStage1;

  localparam int GROUP_BYTES   = `FETCH_WIDTH * 4;
  localparam int READY_TIMEOUT = 40;  // Cycles allowed for a line to arrive

  logic                 clk;
  logic                 reset;
  fetchPkg::redirect_t  backendRedirect;
  fetchPkg::redirect_t  decodeRedirect;
  logic                 stall;
  fetchPkg::btbUpdate_t update;
  fetchPkg::refill_t    refill;
  logic [`PC_WIDTH-1:0] pc;
  fetchPkg::instGroup_t group;
  fetchPkg::groupPred_t pred;
  logic                 ready;
  logic                 miss;
  logic [`PC_WIDTH-1:0] missAddr;

  // Reference model state
  logic [`PC_WIDTH-1:0] mPc;
  logic                 mBtbValid  [`FETCH_WIDTH][`BTB_ENTRIES];
  logic [`PC_WIDTH-1:0] mBtbGroup  [`FETCH_WIDTH][`BTB_ENTRIES];  // Group number as tag
  fetchPkg::ctrlType_e  mBtbType   [`FETCH_WIDTH][`BTB_ENTRIES];
  logic [`PC_WIDTH-1:0] mBtbTarget [`FETCH_WIDTH][`BTB_ENTRIES];
  logic [1:0]           mCounter   [`BPB_ENTRIES];
  logic [`PC_WIDTH-1:0] mRas       [`RAS_DEPTH];
  int                   mRasTop;
  logic                 mLineValid [`ICACHE_LINES];
  logic [`PC_WIDTH-1:0] mLineGroup [`ICACHE_LINES];
  fetchPkg::instGroup_t mLineData  [`ICACHE_LINES];

  // Expected results of the current cycle
  fetchPkg::groupPred_t expPred;
  fetchPkg::instGroup_t expGroup;
  logic [`PC_WIDTH-1:0] expNext;
  logic [`PC_WIDTH-1:0] expPushAddr;
  logic                 expMiss;
  logic                 expPush;
  logic                 expPop;

  int    seed;
  int    errorCount;
  int    testErrors;
  int    testCount;
  string testName;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  fetchStage1 u_fetchStage1 (
    .clk               (clk),
    .reset             (reset),
    .backendRedirect_i (backendRedirect),
    .decodeRedirect_i  (decodeRedirect),
    .stall_i           (stall),
    .update_i          (update),
    .refill_i          (refill),
    .pc_o              (pc),
    .group_o           (group),
    .pred_o            (pred),
    .ready_o           (ready),
    .miss_o            (miss),
    .missAddr_o        (missAddr)
  );

  task automatic checkPc(input string what, input logic [`PC_WIDTH-1:0] expected,
                         input logic [`PC_WIDTH-1:0] actual);
    if (actual !== expected) begin
      errorCount++;
      $display("Fail %s %s expected %h actual %h", testName, what, expected, actual);
    end
  endtask

  task automatic checkGroup(input string what, input fetchPkg::instGroup_t expected,
                            input fetchPkg::instGroup_t actual);
    if (actual !== expected) begin
      errorCount++;
      $display("Fail %s %s expected %h actual %h", testName, what, expected, actual);
    end
  endtask

  task automatic checkPred(input string what, input fetchPkg::groupPred_t expected,
                           input fetchPkg::groupPred_t actual);
    if (actual !== expected) begin
      errorCount++;
      $display("Fail %s %s expected %h actual %h", testName, what, expected, actual);
    end
  endtask

  task automatic checkFlag(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      errorCount++;
      $display("Fail %s %s expected %b actual %b", testName, what, expected, actual);
    end
  endtask

  function automatic logic [`PC_WIDTH-1:0] randomAddr();
    return $random(seed) & 32'h3fc;  // Small window, so entries alias and hit
  endfunction

  function automatic fetchPkg::instGroup_t randomGroup();
    fetchPkg::instGroup_t g;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      g[i] = $random(seed);
    end
    return g;
  endfunction

  task automatic idleInputs();
    backendRedirect = '0;
    decodeRedirect  = '0;
    stall           = 1'b0;
    update          = '0;
    refill          = '0;
  endtask

  task automatic resetModel();
    mPc     = '0;
    mRasTop = 0;
    for (int b = 0; b < `FETCH_WIDTH; b++) begin
      for (int e = 0; e < `BTB_ENTRIES; e++) begin
        mBtbValid[b][e] = 1'b0;
      end
    end
    for (int e = 0; e < `BPB_ENTRIES; e++) begin
      mCounter[e] = 2'd1;  // Weakly not-taken
    end
    for (int e = 0; e < `RAS_DEPTH; e++) begin
      mRas[e] = '0;
    end
    for (int e = 0; e < `ICACHE_LINES; e++) begin
      mLineValid[e] = 1'b0;
    end
  endtask

  // Outputs of the stage from the model PC, slot rules and priority
  task automatic predictModel();
    logic [`PC_WIDTH-1:0] base;
    logic [`PC_WIDTH-1:0] slotAddr;
    logic                 found;
    int                   bIdx;
    int                   lIdx;
    int                   firstSlot;
    base      = mPc - (mPc % GROUP_BYTES);
    bIdx      = (mPc / GROUP_BYTES) % `BTB_ENTRIES;
    lIdx      = (mPc / GROUP_BYTES) % `ICACHE_LINES;
    firstSlot = (mPc % GROUP_BYTES) / 4;
    expMiss   = !(mLineValid[lIdx] && mLineGroup[lIdx] == mPc / GROUP_BYTES);
    expGroup  = mLineData[lIdx];
    expPred   = '0;
    expNext   = base + GROUP_BYTES;  // Fall through
    expPush   = 1'b0;
    expPop    = 1'b0;
    expPushAddr = '0;
    found     = 1'b0;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      slotAddr = base + 4 * i;
      if (i >= firstSlot && mBtbValid[i][bIdx] && mBtbGroup[i][bIdx] == mPc / GROUP_BYTES) begin
        expPred[i].hit      = 1'b1;
        expPred[i].ctrlType = mBtbType[i][bIdx];
        expPred[i].target   = (mBtbType[i][bIdx] == fetchPkg::ctrlReturn) ?
                              mRas[mRasTop] : mBtbTarget[i][bIdx];
        expPred[i].taken    = (mBtbType[i][bIdx] != fetchPkg::ctrlCond) ||
                              (mCounter[(slotAddr / 4) % `BPB_ENTRIES] >= 2'd2);
        if (expPred[i].taken && !found) begin
          found       = 1'b1;
          expNext     = expPred[i].target;
          expPush     = (mBtbType[i][bIdx] == fetchPkg::ctrlCall);
          expPop      = (mBtbType[i][bIdx] == fetchPkg::ctrlReturn);
          expPushAddr = slotAddr + 4;  // Slot after the call
        end
      end
    end
  endtask

  // State change at the coming clock edge
  task automatic advanceModel();
    int bank;
    int idx;
    if (backendRedirect.valid) begin
      mPc = backendRedirect.target;
    end else if (decodeRedirect.valid) begin
      mPc = decodeRedirect.target;
    end else if (!expMiss && !stall) begin
      mPc = expNext;
      if (expPush) begin
        mRasTop       = (mRasTop + 1) % `RAS_DEPTH;
        mRas[mRasTop] = expPushAddr;
      end else if (expPop) begin
        mRasTop = (mRasTop + `RAS_DEPTH - 1) % `RAS_DEPTH;
      end
    end
    if (update.valid && !(update.ctrlType == fetchPkg::ctrlCond && !update.taken)) begin
      bank = (update.pc / 4) % `FETCH_WIDTH;
      idx  = (update.pc / GROUP_BYTES) % `BTB_ENTRIES;
      mBtbValid[bank][idx]  = 1'b1;
      mBtbGroup[bank][idx]  = update.pc / GROUP_BYTES;
      mBtbType[bank][idx]   = update.ctrlType;
      mBtbTarget[bank][idx] = update.target;
    end
    if (update.valid && update.ctrlType == fetchPkg::ctrlCond) begin
      idx = (update.pc / 4) % `BPB_ENTRIES;
      if (update.taken && mCounter[idx] != 2'd3) begin
        mCounter[idx] = mCounter[idx] + 2'd1;
      end else if (!update.taken && mCounter[idx] != 2'd0) begin
        mCounter[idx] = mCounter[idx] - 2'd1;
      end
    end
    if (refill.valid) begin
      idx = (refill.addr / GROUP_BYTES) % `ICACHE_LINES;
      mLineValid[idx] = 1'b1;
      mLineGroup[idx] = refill.addr / GROUP_BYTES;
      mLineData[idx]  = refill.data;
    end
  endtask

  // Called 1 after an edge with inputs driven, returns 1 after the next edge
  task automatic stepCycle();
    #1;
    predictModel();
    checkPc("pc_o", mPc, pc);
    checkPc("missAddr_o", mPc - (mPc % GROUP_BYTES), missAddr);
    checkFlag("ready_o", !expMiss, ready);
    checkFlag("miss_o", expMiss, miss);
    if (!expMiss) begin
      checkGroup("group_o", expGroup, group);
    end
    checkPred("pred_o", expPred, pred);
    advanceModel();
    @(posedge clk);
    #1;
    idleInputs();
  endtask

  task automatic driveRefill();
    refill.valid = 1'b1;
    refill.addr  = mPc - (mPc % GROUP_BYTES);  // Line of the missing group
    refill.data  = randomGroup();
  endtask

  task automatic driveUpdate(input logic [`PC_WIDTH-1:0] branchPc,
                             input logic [`PC_WIDTH-1:0] target,
                             input fetchPkg::ctrlType_e kind, input logic taken);
    update.valid    = 1'b1;
    update.pc       = branchPc;
    update.target   = target;
    update.ctrlType = kind;
    update.taken    = taken;
  endtask

  task automatic redirectTo(input logic [`PC_WIDTH-1:0] target);
    backendRedirect.valid  = 1'b1;
    backendRedirect.target = target;
  endtask

  // Refills at random until the DUT shows a valid group
  task automatic waitReady();
    int waited;
    waited = 0;
    while (!ready) begin
      if (waited == READY_TIMEOUT) begin
        $display("Timeout in %s, ready_o stayed low for %0d cycles", testName, waited);
        $display("Finished with errors");
        $finish;
      end
      if ($random(seed) & 1) begin
        driveRefill();
      end
      stepCycle();
      waited++;
    end
  endtask

  task automatic fetchGroups(input int count);
    repeat (count) begin
      waitReady();
      stepCycle();  // Group taken, no stall
    end
  endtask

  task automatic startTest(input string name);
    testName   = name;
    testErrors = errorCount;
  endtask

  task automatic finishTest();
    testCount++;
    $display("Test %s done with %0d errors", testName, errorCount - testErrors);
  endtask

  initial begin
    logic [`PC_WIDTH-1:0] branchPc;
    logic [`PC_WIDTH-1:0] expectPc;
    seed       = 32'h517a;
    errorCount = 0;
    testCount  = 0;
    testName   = "reset";
    idleInputs();
    resetModel();
    reset = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    // Cold cache, then straight-line fetch
    startTest("coldStart");
    checkFlag("miss_o after reset", 1'b1, miss);
    checkPc("missAddr_o after reset", '0, missAddr);
    driveRefill();
    stepCycle();
    checkFlag("ready_o after refill", 1'b1, ready);
    repeat (6) begin
      waitReady();
      expectPc = mPc - (mPc % GROUP_BYTES) + GROUP_BYTES;
      stepCycle();
      checkPc("sequential pc", expectPc, pc);
    end
    finishTest();

    startTest("jumpTarget");
    repeat (16) begin
      branchPc = randomAddr();
      driveUpdate(branchPc, randomAddr(), fetchPkg::ctrlJump, 1'b1);
      stepCycle();
      redirectTo(branchPc - (branchPc % GROUP_BYTES) + 4 * ($random(seed) & 3));  // Random entry slot
      stepCycle();
      fetchGroups(1);
    end
    finishTest();

    startTest("condTrain");
    repeat (40) begin
      branchPc = $random(seed) & 32'h3c;  // Few slots, counters move a lot
      driveUpdate(branchPc, randomAddr(), fetchPkg::ctrlCond, $random(seed) & 1);
      stepCycle();
      redirectTo(branchPc - (branchPc % GROUP_BYTES));
      stepCycle();
      fetchGroups(1);
    end
    finishTest();

    // Chain of calls at slot 1, returns at slot 2, innermost return at slot 0
    startTest("callReturn");
    for (int k = 1; k <= `RAS_DEPTH; k++) begin
      driveUpdate(32'h1000 + k * 16 + 4, 32'h1000 + (k + 1) * 16, fetchPkg::ctrlCall, 1'b1);
      stepCycle();
      driveUpdate(32'h1000 + k * 16 + 8, '0, fetchPkg::ctrlReturn, 1'b1);
      stepCycle();
    end
    driveUpdate(32'h1000 + (`RAS_DEPTH + 1) * 16, '0, fetchPkg::ctrlReturn, 1'b1);
    stepCycle();
    redirectTo(32'h1010);
    stepCycle();
    fetchGroups(2 * `RAS_DEPTH + 4);
    finishTest();

    startTest("redirectPriority");
    repeat (30) begin
      backendRedirect.valid  = $random(seed) & 1;
      backendRedirect.target = randomAddr();
      decodeRedirect.valid   = $random(seed) & 1;
      decodeRedirect.target  = randomAddr();
      stall                  = $random(seed) & 1;
      if (!ready && ($random(seed) & 1)) begin
        driveRefill();
      end
      stepCycle();
    end
    finishTest();

    startTest("stallMiss");
    repeat (200) begin
      stall = $random(seed) & 1;
      if (($random(seed) & 15) == 0) begin
        redirectTo(randomAddr());
      end
      if (($random(seed) % 5) == 0) begin
        driveUpdate(randomAddr(), randomAddr(), fetchPkg::ctrlType_e'($random(seed) & 3),
                    $random(seed) & 1);
      end
      if (!ready && (($random(seed) % 3) == 0)) begin
        driveRefill();
      end
      stepCycle();
    end
    finishTest();

    $display("Tests run %0d, errors %0d", testCount, errorCount);
    if (errorCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: fetchStage1.sv
`include "fetch_params.svh"

module fetchStage1 (
  input  logic                   clk,
  input  logic                   reset,
  input  fetchPkg::redirect_t    backendRedirect_i,
  input  fetchPkg::redirect_t    decodeRedirect_i,
  input  logic                   stall_i,
  input  fetchPkg::btbUpdate_t   update_i,
  input  fetchPkg::refill_t      refill_i,
  output logic [`PC_WIDTH-1:0]   pc_o,
  output fetchPkg::instGroup_t   group_o,
  output fetchPkg::groupPred_t   pred_o,
  output logic                   ready_o,
  output logic                   miss_o,
  output logic [`PC_WIDTH-1:0]   missAddr_o
);

  localparam int PCW        = `PC_WIDTH;
  localparam int FW         = `FETCH_WIDTH;
  localparam int SLOT_BITS  = $clog2(FW);
  localparam int GROUP_BITS = SLOT_BITS + 2;  // Byte offset inside a group

  logic [PCW-1:0]            pcReg;
  logic [PCW-1:0]            pcNext;
  logic [PCW-1:0]            predPc;
  logic [PCW-1:0]            groupBase;
  logic [SLOT_BITS-1:0]      slotOff;
  logic [FW-1:0]             btbHit;
  fetchPkg::ctrlType_e [FW-1:0] btbType;
  logic [FW-1:0][PCW-1:0]    btbTarget;
  logic [FW-1:0]             counterTaken;
  logic [FW-1:0]             slotTaken;
  fetchPkg::groupPred_t      predGroup;
  fetchPkg::btbUpdate_t      btbWrite;
  logic                      bpbWrite;
  logic [PCW-1:0]            rasTop;
  logic [PCW-1:0]            pushAddr;
  logic                      pushReq;
  logic                      popReq;
  logic                      miss;
  logic                      advance;
  logic                      anyRedirect;

  assign groupBase = {pcReg[PCW-1:GROUP_BITS], {GROUP_BITS{1'b0}}};
  assign slotOff   = pcReg[GROUP_BITS-1:2];  // First live slot

  // BTB skips not-taken conditionals, predictor sees only conditionals
  always_comb begin
    btbWrite       = update_i;
    btbWrite.valid = update_i.valid &&
                     !(update_i.ctrlType == fetchPkg::ctrlCond && !update_i.taken);
  end
  assign bpbWrite = update_i.valid && (update_i.ctrlType == fetchPkg::ctrlCond);

  branchTargetBuffer u_btb (
    .clk      (clk),
    .reset    (reset),
    .pc_i     (pcReg),
    .update_i (btbWrite),
    .hit_o    (btbHit),
    .type_o   (btbType),
    .target_o (btbTarget)
  );

  directionPredictor u_bpb (
    .clk           (clk),
    .reset         (reset),
    .pc_i          (pcReg),
    .updatePc_i    (update_i.pc),
    .updateTaken_i (update_i.taken),
    .updateEn_i    (bpbWrite),
    .taken_o       (counterTaken)
  );

  // Stack moves only when the group really leaves and nothing redirects
  returnAddrStack u_ras (
    .clk        (clk),
    .reset      (reset),
    .push_i     (pushReq && advance && !anyRedirect),
    .pop_i      (popReq && advance && !anyRedirect),
    .pushAddr_i (pushAddr),
    .top_o      (rasTop)
  );

  instCache u_icache (
    .clk        (clk),
    .reset      (reset),
    .pc_i       (pcReg),
    .refill_i   (refill_i),
    .group_o    (group_o),
    .miss_o     (miss),
    .missAddr_o (missAddr_o)
  );

  // Per-slot taken decision, slots before the PC offset stay zero
  always_comb begin
    predGroup = '0;
    slotTaken = '0;
    for (int i = 0; i < FW; i++) begin
      if (SLOT_BITS'(i) >= slotOff) begin
        slotTaken[i] = btbHit[i] &&
                       (btbType[i] != fetchPkg::ctrlCond || counterTaken[i]);
        predGroup[i].hit      = btbHit[i];
        predGroup[i].ctrlType = btbType[i];
        predGroup[i].target   = (btbHit[i] && btbType[i] == fetchPkg::ctrlReturn) ?
                                rasTop : btbTarget[i];
        predGroup[i].taken    = slotTaken[i];
      end
    end
  end

  // Lowest taken slot steers the PC and the RAS
  always_comb begin : selectSlot
    logic found;
    found    = 1'b0;
    predPc   = groupBase + PCW'(FW * 4);  // Fall through to next group
    pushReq  = 1'b0;
    popReq   = 1'b0;
    pushAddr = groupBase;
    for (int i = 0; i < FW; i++) begin
      if (slotTaken[i] && !found) begin
        found    = 1'b1;
        predPc   = predGroup[i].target;
        pushReq  = (btbType[i] == fetchPkg::ctrlCall);
        popReq   = (btbType[i] == fetchPkg::ctrlReturn);
        pushAddr = groupBase + PCW'((i + 1) * 4);  // Slot after the call
      end
    end
  end

  // Backend over decode over prediction
  always_comb begin
    if (backendRedirect_i.valid) begin
      pcNext = backendRedirect_i.target;
    end else if (decodeRedirect_i.valid) begin
      pcNext = decodeRedirect_i.target;
    end else begin
      pcNext = predPc;
    end
  end

  assign anyRedirect = backendRedirect_i.valid || decodeRedirect_i.valid;
  assign advance     = ready_o && !stall_i;  // Group handed over

  always_ff @(posedge clk) begin
    if (reset) begin
      pcReg <= '0;
    end else if (anyRedirect || advance) begin
      pcReg <= pcNext;  // Miss or stall holds it
    end
  end

  assign pc_o    = pcReg;
  assign pred_o  = predGroup;
  assign ready_o = !miss;
  assign miss_o  = miss;

  // A missing group holds the PC unless redirected
  missHoldsPc: assert property (@(posedge clk) disable iff (reset)
    (miss_o && !anyRedirect) |=> $stable(pc_o));

endmodule

// File: instCache.sv
`include "fetch_params.svh"

module instCache (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [`PC_WIDTH-1:0]  pc_i,
  input  fetchPkg::refill_t     refill_i,
  output fetchPkg::instGroup_t  group_o,
  output logic                  miss_o,
  output logic [`PC_WIDTH-1:0]  missAddr_o
);

  localparam int OFFSET_BITS = $clog2(`FETCH_WIDTH * 4);  // Byte offset in a line
  localparam int IDX_BITS    = $clog2(`ICACHE_LINES);
  localparam int TAG_LSB     = OFFSET_BITS + IDX_BITS;
  localparam int TAG_BITS    = `PC_WIDTH - TAG_LSB;

  logic [`ICACHE_LINES-1:0] lineValid;
  logic [TAG_BITS-1:0]      lineTag  [`ICACHE_LINES];
  fetchPkg::instGroup_t     lineData [`ICACHE_LINES];

  logic [IDX_BITS-1:0] rdIdx;
  logic [TAG_BITS-1:0] rdTag;
  logic [IDX_BITS-1:0] wrIdx;

  assign rdIdx = pc_i[OFFSET_BITS +: IDX_BITS];
  assign rdTag = pc_i[`PC_WIDTH-1:TAG_LSB];
  assign wrIdx = refill_i.addr[OFFSET_BITS +: IDX_BITS];

  // Read path, all combinational from the PC
  assign group_o    = lineData[rdIdx];
  assign miss_o     = !lineValid[rdIdx] || (lineTag[rdIdx] != rdTag);
  assign missAddr_o = {pc_i[`PC_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};  // Line base

  always_ff @(posedge clk) begin
    if (reset) begin
      lineValid <= '0;  // Cold cache
    end else if (refill_i.valid) begin
      lineValid[wrIdx] <= 1'b1;
    end
  end

  // Whole line written at once, hits from the next cycle
  always_ff @(posedge clk) begin
    if (refill_i.valid) begin
      lineTag[wrIdx]  <= refill_i.addr[`PC_WIDTH-1:TAG_LSB];
      lineData[wrIdx] <= refill_i.data;
    end
  end

  refillAligned: assert property (@(posedge clk) disable iff (reset)
    refill_i.valid |-> (refill_i.addr[OFFSET_BITS-1:0] == '0));

endmodule

// File: returnAddrStack.sv
`include "fetch_params.svh"

module returnAddrStack (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  push_i,
  input  logic                  pop_i,
  input  logic [`PC_WIDTH-1:0]  pushAddr_i,
  output logic [`PC_WIDTH-1:0]  top_o
);

  localparam int PTR_BITS = $clog2(`RAS_DEPTH);

  logic [`PC_WIDTH-1:0] stack [`RAS_DEPTH];
  logic [PTR_BITS-1:0]  topPtr;
  logic [PTR_BITS-1:0]  ptrInc;
  logic [PTR_BITS-1:0]  ptrDec;

  // Pointers wrap, so overflow drops the oldest entry
  assign ptrInc = topPtr + 1'b1;
  assign ptrDec = topPtr - 1'b1;

  assign top_o = stack[topPtr];  // Underflow shows whatever wrapped in

  always_ff @(posedge clk) begin
    if (reset) begin
      topPtr <= '0;
      for (int e = 0; e < `RAS_DEPTH; e++) begin
        stack[e] <= '0;
      end
    end else if (push_i && pop_i) begin
      stack[topPtr] <= pushAddr_i;  // Return then call, top replaced
    end else if (push_i) begin
      topPtr         <= ptrInc;
      stack[ptrInc]  <= pushAddr_i;
    end else if (pop_i) begin
      topPtr <= ptrDec;
    end
  end

  // Combined push and pop must still carry a real address
  pushPopAddrKnown: assert property (@(posedge clk) disable iff (reset)
    (push_i && pop_i) |-> !$isunknown(pushAddr_i));

endmodule

// File: directionPredictor.sv
`include "fetch_params.svh"

module directionPredictor (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`PC_WIDTH-1:0]     pc_i,
  input  logic [`PC_WIDTH-1:0]     updatePc_i,
  input  logic                     updateTaken_i,
  input  logic                     updateEn_i,
  output logic [`FETCH_WIDTH-1:0]  taken_o
);

  localparam int SLOT_BITS = $clog2(`FETCH_WIDTH);
  localparam int IDX_BITS  = $clog2(`BPB_ENTRIES);

  logic [1:0]          counter [`BPB_ENTRIES];
  logic [IDX_BITS-1:0] wrIdx;

  assign wrIdx = updatePc_i[IDX_BITS+1:2];  // Instruction address bits

  // Each slot reads its own counter
  always_comb begin : slotRead
    logic [IDX_BITS-1:0] rdIdx;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      rdIdx      = {pc_i[IDX_BITS+1:SLOT_BITS+2], SLOT_BITS'(i)};
      taken_o[i] = counter[rdIdx][1];  // Taken at 2 or 3
    end
  end

  // Saturating 2-bit update
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int e = 0; e < `BPB_ENTRIES; e++) begin
        counter[e] <= 2'd1;  // Weakly not-taken
      end
    end else if (updateEn_i) begin
      if (updateTaken_i && counter[wrIdx] != 2'd3) begin
        counter[wrIdx] <= counter[wrIdx] + 2'd1;
      end else if (!updateTaken_i && counter[wrIdx] != 2'd0) begin
        counter[wrIdx] <= counter[wrIdx] - 2'd1;
      end
    end
  end

endmodule

// File: branchTargetBuffer.sv
`include "fetch_params.svh"

module branchTargetBuffer (
  input  logic                                        clk,
  input  logic                                        reset,
  input  logic                 [`PC_WIDTH-1:0]        pc_i,
  input  fetchPkg::btbUpdate_t                        update_i,
  output logic                 [`FETCH_WIDTH-1:0]     hit_o,
  output fetchPkg::ctrlType_e  [`FETCH_WIDTH-1:0]     type_o,
  output logic [`FETCH_WIDTH-1:0][`PC_WIDTH-1:0]      target_o
);

  localparam int SLOT_BITS = $clog2(`FETCH_WIDTH);
  localparam int IDX_BITS  = $clog2(`BTB_ENTRIES);
  localparam int IDX_LSB   = SLOT_BITS + 2;        // First bit above the group offset
  localparam int TAG_LSB   = IDX_LSB + IDX_BITS;
  localparam int TAG_BITS  = `PC_WIDTH - TAG_LSB;

  // One bank per slot position
  logic [`FETCH_WIDTH-1:0][`BTB_ENTRIES-1:0] entryValid;
  logic [TAG_BITS-1:0]       entryTag    [`FETCH_WIDTH][`BTB_ENTRIES];
  fetchPkg::ctrlType_e       entryType   [`FETCH_WIDTH][`BTB_ENTRIES];
  logic [`PC_WIDTH-1:0]      entryTarget [`FETCH_WIDTH][`BTB_ENTRIES];

  logic [IDX_BITS-1:0]  rdIdx;
  logic [TAG_BITS-1:0]  rdTag;
  logic [IDX_BITS-1:0]  wrIdx;
  logic [TAG_BITS-1:0]  wrTag;
  logic [SLOT_BITS-1:0] wrBank;

  assign rdIdx  = pc_i[IDX_LSB +: IDX_BITS];             // Same index in every bank
  assign rdTag  = pc_i[`PC_WIDTH-1:TAG_LSB];
  assign wrIdx  = update_i.pc[IDX_LSB +: IDX_BITS];
  assign wrTag  = update_i.pc[`PC_WIDTH-1:TAG_LSB];
  assign wrBank = update_i.pc[2 +: SLOT_BITS];           // Slot of the branch

  // Lookup of all banks for the current group
  always_comb begin
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      hit_o[i]    = entryValid[i][rdIdx] && (entryTag[i][rdIdx] == rdTag);
      type_o[i]   = hit_o[i] ? entryType[i][rdIdx] : fetchPkg::ctrlReturn;  // Zero on miss
      target_o[i] = hit_o[i] ? entryTarget[i][rdIdx] : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      entryValid <= '0;
    end else if (update_i.valid) begin
      entryValid[wrBank][wrIdx] <= 1'b1;
    end
  end

  // Payload of the written entry, old value seen by a same-cycle lookup
  always_ff @(posedge clk) begin
    if (update_i.valid) begin
      entryTag[wrBank][wrIdx]    <= wrTag;
      entryType[wrBank][wrIdx]   <= update_i.ctrlType;
      entryTarget[wrBank][wrIdx] <= update_i.target;
    end
  end

  // Top level filters out not-taken conditionals
  notTakenCondFiltered: assert property (@(posedge clk) disable iff (reset)
    (update_i.valid && update_i.ctrlType == fetchPkg::ctrlCond) |-> update_i.taken);

endmodule

// File: fetchPkg.sv
`include "fetch_params.svh"

package fetchPkg;

  // Control-instruction class, kept in the BTB and carried on updates
  typedef enum logic [1:0] {
    ctrlReturn = 2'd0,
    ctrlCall   = 2'd1,
    ctrlJump   = 2'd2,
    ctrlCond   = 2'd3
  } ctrlType_e;

  // Redirect from backend or decode
  typedef struct packed {
    logic                 valid;
    logic [`PC_WIDTH-1:0] target;
  } redirect_t;

  // In-order resolved branch from the branch queue
  typedef struct packed {
    logic                 valid;
    logic [`PC_WIDTH-1:0] pc;
    logic [`PC_WIDTH-1:0] target;
    ctrlType_e            ctrlType;
    logic                 taken;  // Resolved direction
  } btbUpdate_t;

  // Per-slot prediction handed to decode
  typedef struct packed {
    logic                 hit;
    ctrlType_e            ctrlType;
    logic [`PC_WIDTH-1:0] target;  // RAS top for returns
    logic                 taken;
  } slotPred_t;

  typedef slotPred_t [`FETCH_WIDTH-1:0] groupPred_t;

  typedef logic [`FETCH_WIDTH-1:0][31:0] instGroup_t;

  // Line fill from the lower memory level, one-cycle pulse
  typedef struct packed {
    logic                 valid;
    logic [`PC_WIDTH-1:0] addr;  // Line address, group aligned
    instGroup_t           data;
  } refill_t;

endpackage

// File: fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Address width of the core
`define PC_WIDTH 32

// Instructions per fetch group, groups are 16-byte aligned
`define FETCH_WIDTH 4

// Entries in each per-slot BTB bank
`define BTB_ENTRIES 16

// 2-bit counters in the bimodal table
`define BPB_ENTRIES 256

// Return address stack entries
`define RAS_DEPTH 8

// Direct-mapped cache lines
// One line holds exactly one fetch group
`define ICACHE_LINES 32

`endif
